// File: rtl/mem_sched_pkg.sv
//////////////////////////////////////////////////////////////
// Shared widths, opcodes and request/response structs of the
// memory request scheduler. Imported by every module.
//////////////////////////////////////////////////////////////
package mem_sched_pkg;

    localparam int CORE_REQS    = 4;
    localparam int MEM_CHANNELS = 2;
    localparam int MEM_BATCHES  = CORE_REQS / MEM_CHANNELS;
    localparam int BATCH_BITS   = $clog2(MEM_BATCHES);
    localparam int WORD_WIDTH   = 32;
    localparam int BYTEEN_WIDTH = WORD_WIDTH / 8;
    localparam int ADDR_WIDTH   = 30;
    localparam int TAG_WIDTH    = 8;
    localparam int NUM_SLOTS    = 4;
    localparam int SLOT_BITS    = $clog2(NUM_SLOTS);

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic [BYTEEN_WIDTH-1:0] byteen;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [WORD_WIDTH-1:0]   data;
    } lane_t;

    typedef struct packed {
        mem_op_e                op;
        logic [CORE_REQS-1:0]   mask;
        lane_t [CORE_REQS-1:0]  lanes;
        logic [TAG_WIDTH-1:0]   tag;
    } core_req_t;

    // Core tag swapped for the slot index while queued
    typedef struct packed {
        mem_op_e                op;
        logic [CORE_REQS-1:0]   mask;
        lane_t [CORE_REQS-1:0]  lanes;
        logic [SLOT_BITS-1:0]   slot;
    } queued_req_t;

    typedef struct packed {
        logic [SLOT_BITS-1:0]  slot;
        logic [BATCH_BITS-1:0] batch;
    } mem_tag_t;

    typedef struct packed {
        mem_op_e                  op;
        logic [MEM_CHANNELS-1:0]  mask;
        lane_t [MEM_CHANNELS-1:0] lanes;
        mem_tag_t                 tag;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_CHANNELS-1:0]                 mask;
        logic [MEM_CHANNELS-1:0][WORD_WIDTH-1:0] data;
        mem_tag_t                                tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [CORE_REQS-1:0]                 mask;
        logic [CORE_REQS-1:0][WORD_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0]                 tag;
    } core_rsp_t;

endpackage

// File: rtl/req_queue.sv
//////////////////////////////////////////////////////////////
// Request FIFO with a registered head, one entry in and one
// entry out per cycle over valid/ready.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module req_queue import mem_sched_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  queued_req_t in_req,
    input  logic        in_valid,
    output logic        in_ready,
    output queued_req_t out_req,
    output logic        out_valid,
    input  logic        out_ready
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    queued_req_t         entries [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                head_free;
    logic                push;
    logic                load;
    logic                bypass;
    logic                store;

    function automatic logic [PTR_BITS-1:0] incr_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_free = !out_valid || out_ready;
    assign in_ready  = (count != CNT_BITS'(DEPTH));
    assign push      = in_valid && in_ready;
    assign load      = head_free && (count != '0);
    // Empty storage lets a new entry go straight to the head
    assign bypass    = head_free && (count == '0) && push;
    assign store     = push && !bypass;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (store) begin
                wr_ptr <= incr_ptr(wr_ptr);
            end
            if (load) begin
                rd_ptr <= incr_ptr(rd_ptr);
            end
            if (store && !load) begin
                count <= count + 1'b1;
            end else if (load && !store) begin
                count <= count - 1'b1;
            end
            if (head_free) begin
                out_valid <= load || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            entries[wr_ptr] <= in_req;
        end
        if (load) begin
            out_req <= entries[rd_ptr];
        end else if (bypass) begin
            out_req <= in_req;
        end
    end

endmodule

// File: rtl/slot_table.sv
//////////////////////////////////////////////////////////////
// Read slot allocation and admission control. Holds the core
// tag of each outstanding read until its response is sent.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module slot_table import mem_sched_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 core_req_valid,
    input  mem_op_e              core_op,
    input  logic [TAG_WIDTH-1:0] core_tag,
    input  logic                 queue_ready,
    output logic                 core_req_ready,
    output logic                 alloc,
    output logic [SLOT_BITS-1:0] alloc_slot,
    input  logic                 release_en,
    input  logic [SLOT_BITS-1:0] release_slot,
    input  logic [SLOT_BITS-1:0] lookup_slot,
    output logic [TAG_WIDTH-1:0] lookup_tag
);

    logic [NUM_SLOTS-1:0] free_mask;
    logic [TAG_WIDTH-1:0] tag_mem [NUM_SLOTS];
    logic                 any_free;

    // Lowest free slot wins
    always_comb begin
        alloc_slot = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                alloc_slot = SLOT_BITS'(i);
            end
        end
    end

    assign any_free       = |free_mask;
    assign core_req_ready = queue_ready && ((core_op == MEM_WRITE) || any_free);
    assign alloc          = core_req_valid && core_req_ready && (core_op == MEM_READ);
    assign lookup_tag     = tag_mem[lookup_slot];

    always_ff @(posedge clk) begin
        if (reset) begin
            free_mask <= '1;
        end else begin
            if (release_en) begin
                free_mask[release_slot] <= 1'b1;
            end
            if (alloc) begin
                free_mask[alloc_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[alloc_slot] <= core_tag;
        end
    end

endmodule

// File: rtl/batch_issuer.sv
//////////////////////////////////////////////////////////////
// Splits the queue head into two-lane memory requests, skips
// empty batches and drives the registered memory request.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module batch_issuer import mem_sched_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  queued_req_t head,
    input  logic        head_valid,
    output logic        head_ready,
    output mem_req_t    mem_req,
    output logic        mem_req_valid,
    input  logic        mem_req_ready
);

    logic [BATCH_BITS-1:0]  batch_idx;
    logic [BATCH_BITS-1:0]  sel;
    logic [MEM_BATCHES-1:0] batch_active;
    logic                   found;
    logic                   is_last;
    logic                   out_free;
    logic                   issue;

    always_comb begin
        for (int b = 0; b < MEM_BATCHES; b++) begin
            batch_active[b] = |head.mask[b*MEM_CHANNELS +: MEM_CHANNELS];
        end
    end

    // Next active batch at or after the current index
    always_comb begin
        sel     = '0;
        found   = 1'b0;
        is_last = 1'b1;
        for (int b = 0; b < MEM_BATCHES; b++) begin
            if (batch_active[b] && (b >= int'(batch_idx))) begin
                if (!found) begin
                    sel   = BATCH_BITS'(b);
                    found = 1'b1;
                end else begin
                    is_last = 1'b0;
                end
            end
        end
    end

    assign out_free   = !mem_req_valid || mem_req_ready;
    // An all-zero mask pops the head without issuing
    assign head_ready = out_free && (!found || is_last);
    assign issue      = head_valid && out_free && found;

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx     <= '0;
            mem_req_valid <= 1'b0;
        end else begin
            if (head_valid && head_ready) begin
                batch_idx <= '0;
            end else if (issue) begin
                batch_idx <= sel + 1'b1;
            end
            if (out_free) begin
                mem_req_valid <= issue;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_req.op        <= head.op;
            mem_req.mask      <= head.mask[sel*MEM_CHANNELS +: MEM_CHANNELS];
            mem_req.tag.slot  <= head.slot;
            mem_req.tag.batch <= sel;
            for (int c = 0; c < MEM_CHANNELS; c++) begin
                mem_req.lanes[c] <= head.lanes[sel*MEM_CHANNELS + c];
            end
        end
    end

endmodule

// File: rtl/rsp_gatherer.sv
//////////////////////////////////////////////////////////////
// Collects out-of-order memory responses per slot and returns
// each read to the core as one complete response.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module rsp_gatherer import mem_sched_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc,
    input  logic [SLOT_BITS-1:0] alloc_slot,
    input  logic [CORE_REQS-1:0] alloc_mask,
    input  mem_rsp_t             mem_rsp,
    input  logic                 mem_rsp_valid,
    output logic                 mem_rsp_ready,
    output logic [SLOT_BITS-1:0] lookup_slot,
    input  logic [TAG_WIDTH-1:0] lookup_tag,
    output core_rsp_t            core_rsp,
    output logic                 core_rsp_valid,
    input  logic                 core_rsp_ready,
    output logic                 release_en,
    output logic [SLOT_BITS-1:0] release_slot
);

    logic [CORE_REQS-1:0]                 orig_mask [NUM_SLOTS];
    logic [CORE_REQS-1:0]                 rem_mask [NUM_SLOTS];
    logic [CORE_REQS-1:0][WORD_WIDTH-1:0] data_store [NUM_SLOTS];

    logic [SLOT_BITS-1:0]                 rsp_slot;
    logic [BATCH_BITS-1:0]                rsp_batch;
    logic [SLOT_BITS-1:0]                 held_slot;
    logic [CORE_REQS-1:0]                 curr_mask;
    logic [CORE_REQS-1:0]                 rem_next;
    logic [CORE_REQS-1:0][WORD_WIDTH-1:0] data_next;
    logic                                 rsp_fire;
    logic                                 complete;

    assign rsp_slot  = mem_rsp.tag.slot;
    assign rsp_batch = mem_rsp.tag.batch;

    // Lane r sits in batch r / MEM_CHANNELS, channel r % MEM_CHANNELS
    always_comb begin
        data_next = data_store[rsp_slot];
        for (int r = 0; r < CORE_REQS; r++) begin
            curr_mask[r] = ((r / MEM_CHANNELS) == int'(rsp_batch))
                           && mem_rsp.mask[r % MEM_CHANNELS];
            if (curr_mask[r]) begin
                data_next[r] = mem_rsp.data[r % MEM_CHANNELS];
            end
        end
    end

    assign rem_next      = rem_mask[rsp_slot] & ~curr_mask;
    assign complete      = (rem_next == '0);
    assign mem_rsp_ready = !core_rsp_valid || core_rsp_ready;
    assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;

    assign lookup_slot   = rsp_slot;
    assign release_en    = core_rsp_valid && core_rsp_ready;
    assign release_slot  = held_slot;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_rsp_valid <= 1'b0;
        end else if (rsp_fire && complete) begin
            core_rsp_valid <= 1'b1;
        end else if (core_rsp_ready) begin
            core_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            orig_mask[alloc_slot] <= alloc_mask;
            rem_mask[alloc_slot]  <= alloc_mask;
        end
        if (rsp_fire) begin
            rem_mask[rsp_slot]   <= rem_next;
            data_store[rsp_slot] <= data_next;
        end
        // Response register loads on the last lane of a read
        if (rsp_fire && complete) begin
            core_rsp.mask <= orig_mask[rsp_slot];
            core_rsp.data <= data_next;
            core_rsp.tag  <= lookup_tag;
            held_slot     <= rsp_slot;
        end
    end

endmodule

// File: rtl/mem_scheduler.sv
//////////////////////////////////////////////////////////////
// Memory request scheduler top level. Queues core requests,
// issues them in two-lane batches and gathers read responses.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module mem_scheduler import mem_sched_pkg::*; #(
    parameter int REQ_QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t core_req,
    input  logic      core_req_valid,
    output logic      core_req_ready,

    output core_rsp_t core_rsp,
    output logic      core_rsp_valid,
    input  logic      core_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,

    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready
);

    queued_req_t          q_in;
    queued_req_t          q_head;
    logic                 q_in_valid;
    logic                 q_in_ready;
    logic                 q_head_valid;
    logic                 q_head_ready;

    logic                 alloc;
    logic [SLOT_BITS-1:0] alloc_slot;
    logic                 release_en;
    logic [SLOT_BITS-1:0] release_slot;
    logic [SLOT_BITS-1:0] lookup_slot;
    logic [TAG_WIDTH-1:0] lookup_tag;

    // Queue entry carries the slot in place of the core tag
    assign q_in.op    = core_req.op;
    assign q_in.mask  = core_req.mask;
    assign q_in.lanes = core_req.lanes;
    assign q_in.slot  = alloc_slot;
    assign q_in_valid = core_req_valid && core_req_ready;

    slot_table slot_table_i (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_op        (core_req.op),
        .core_tag       (core_req.tag),
        .queue_ready    (q_in_ready),
        .core_req_ready (core_req_ready),
        .alloc          (alloc),
        .alloc_slot     (alloc_slot),
        .release_en     (release_en),
        .release_slot   (release_slot),
        .lookup_slot    (lookup_slot),
        .lookup_tag     (lookup_tag)
    );

    req_queue #(
        .DEPTH (REQ_QUEUE_DEPTH)
    ) req_queue_i (
        .clk       (clk),
        .reset     (reset),
        .in_req    (q_in),
        .in_valid  (q_in_valid),
        .in_ready  (q_in_ready),
        .out_req   (q_head),
        .out_valid (q_head_valid),
        .out_ready (q_head_ready)
    );

    batch_issuer batch_issuer_i (
        .clk           (clk),
        .reset         (reset),
        .head          (q_head),
        .head_valid    (q_head_valid),
        .head_ready    (q_head_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready)
    );

    rsp_gatherer rsp_gatherer_i (
        .clk            (clk),
        .reset          (reset),
        .alloc          (alloc),
        .alloc_slot     (alloc_slot),
        .alloc_mask     (core_req.mask),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .lookup_slot    (lookup_slot),
        .lookup_tag     (lookup_tag),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .release_en     (release_en),
        .release_slot   (release_slot)
    );

endmodule

// File: dv/mem_sched_assertions.sv
//////////////////////////////////////////////////////////////
// Handshake and request-mask checks, bound to the scheduler.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module mem_sched_assertions import mem_sched_pkg::*; (
    input logic      clk,
    input logic      reset,
    input core_rsp_t core_rsp,
    input logic      core_rsp_valid,
    input logic      core_rsp_ready,
    input mem_req_t  mem_req,
    input logic      mem_req_valid,
    input logic      mem_req_ready
);

    core_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else $error("core_rsp dropped or changed while stalled");

    mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req dropped or changed while stalled");

    // Empty batches must be skipped
    mem_req_mask: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> (mem_req.mask != '0))
        else $error("mem_req issued with an all-zero channel mask");

    core_rsp_reset: assert property (@(posedge clk)
        reset |=> !core_rsp_valid)
        else $error("core_rsp_valid high after reset");

endmodule

bind mem_scheduler mem_sched_assertions assertions_i (
    .clk            (clk),
    .reset          (reset),
    .core_rsp       (core_rsp),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_ready (core_rsp_ready),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready)
);

// File: dv/tb_mem_scheduler.sv
//////////////////////////////////////////////////////////////
// Testbench for the scheduler: table-driven core requests, a
// memory model answering reads out of order, and a checker.
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_mem_scheduler import mem_sched_pkg::*; ();

    localparam int NUM_STIM   = 15;
    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        mem_op_e                 op;
        logic [CORE_REQS-1:0]    mask;
        logic [ADDR_WIDTH-1:0]   base;
        logic [BYTEEN_WIDTH-1:0] byteen;
        logic [WORD_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
    } stim_t;

    // op, lane mask, base address, byte enables, write data, tag
    localparam stim_t STIM [NUM_STIM] = '{
        '{MEM_READ,  4'b1111, 30'h100, 4'hf,    32'h0,        8'h10},
        '{MEM_READ,  4'b0011, 30'h200, 4'hf,    32'h0,        8'h11},
        '{MEM_READ,  4'b1100, 30'h300, 4'hf,    32'h0,        8'h12},
        '{MEM_WRITE, 4'b1111, 30'h100, 4'b0101, 32'ha1b2c3d4, 8'h00},
        '{MEM_READ,  4'b1111, 30'h100, 4'hf,    32'h0,        8'h13},
        '{MEM_WRITE, 4'b0000, 30'h500, 4'hf,    32'hffffffff, 8'h00},
        '{MEM_WRITE, 4'b0110, 30'h300, 4'b1000, 32'h77000000, 8'h00},
        '{MEM_READ,  4'b1111, 30'h400, 4'hf,    32'h0,        8'h20},
        '{MEM_READ,  4'b1111, 30'h410, 4'hf,    32'h0,        8'h21},
        '{MEM_READ,  4'b1111, 30'h420, 4'hf,    32'h0,        8'h22},
        '{MEM_READ,  4'b1111, 30'h430, 4'hf,    32'h0,        8'h23},
        '{MEM_READ,  4'b1111, 30'h440, 4'hf,    32'h0,        8'h24},
        '{MEM_READ,  4'b1110, 30'h300, 4'hf,    32'h0,        8'h25},
        '{MEM_READ,  4'b1001, 30'h104, 4'hf,    32'h0,        8'h26},
        '{MEM_READ,  4'b0100, 30'h200, 4'hf,    32'h0,        8'h27}
    };

    logic      clk;
    logic      reset;
    core_req_t core_req;
    logic      core_req_valid;
    logic      core_req_ready;
    core_rsp_t core_rsp;
    logic      core_rsp_valid;
    logic      core_rsp_ready;
    mem_req_t  mem_req;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;

    mem_req_t              exp_mem_q [$];
    mem_rsp_t              rsp_pend [$];
    logic [TAG_WIDTH-1:0]  done_q [$];
    logic [WORD_WIDTH-1:0] mem_words [logic [ADDR_WIDTH-1:0]];
    logic [WORD_WIDTH-1:0] exp_data [2**TAG_WIDTH][CORE_REQS];
    logic [CORE_REQS-1:0]  exp_mask [2**TAG_WIDTH];
    logic [CORE_REQS-1:0]  lanes_left [2**TAG_WIDTH];
    logic [SLOT_BITS-1:0]  tag_slot [2**TAG_WIDTH];
    logic [TAG_WIDTH-1:0]  slot_tag [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  slot_busy = '0;
    int                    open_reads = 0;
    int                    stall_cycles = 0;
    int                    check_errors = 0;
    int                    other_errors = 0;

    mem_scheduler #(
        .REQ_QUEUE_DEPTH (4)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic core_req_t make_req(input stim_t s);
        core_req_t r;
        r.op   = s.op;
        r.mask = s.mask;
        r.tag  = s.tag;
        for (int l = 0; l < CORE_REQS; l++) begin
            r.lanes[l].addr   = s.base + ADDR_WIDTH'(l);
            r.lanes[l].byteen = s.byteen;
            r.lanes[l].data   = s.data + WORD_WIDTH'(l);
        end
        return r;
    endfunction

    // Unwritten words hold their address XOR a fixed pattern
    function automatic logic [WORD_WIDTH-1:0] read_word(input logic [ADDR_WIDTH-1:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return {{(WORD_WIDTH-ADDR_WIDTH){1'b0}}, a} ^ 32'h5a5a0000;
    endfunction

    task automatic check_core_rsp(input core_rsp_t got, input core_rsp_t expected,
                                  input string what);
        core_rsp_t g;
        core_rsp_t e;
        g = got;
        e = expected;
        // Inactive lanes carry no data
        for (int l = 0; l < CORE_REQS; l++) begin
            if (!expected.mask[l]) begin
                g.data[l] = '0;
                e.data[l] = '0;
            end
        end
        if (g !== e) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, g, e);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t expected,
                                 input string what);
        if (got !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, got, expected);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic observe_core_req();
        logic [SLOT_BITS-1:0] slot;
        mem_req_t             em;
        slot = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (!slot_busy[s]) begin
                slot = SLOT_BITS'(s);
            end
        end
        if (core_req_valid && core_req.op == MEM_READ && slot_busy == '1) begin
            if (core_req_ready) begin
                other_errors++;
                $display("Error at %0t: a read was accepted with every slot busy", $time);
            end else begin
                stall_cycles++;
            end
        end
        if (!(core_req_valid && core_req_ready)) begin
            return;
        end
        if (core_req.op == MEM_READ) begin
            slot_busy[slot]          = 1'b1;
            slot_tag[slot]           = core_req.tag;
            tag_slot[core_req.tag]   = slot;
            exp_mask[core_req.tag]   = core_req.mask;
            lanes_left[core_req.tag] = core_req.mask;
            open_reads++;
        end
        for (int b = 0; b < MEM_BATCHES; b++) begin
            if (core_req.mask[b*MEM_CHANNELS +: MEM_CHANNELS] != '0) begin
                em.op        = core_req.op;
                em.mask      = core_req.mask[b*MEM_CHANNELS +: MEM_CHANNELS];
                em.tag.slot  = slot;
                em.tag.batch = BATCH_BITS'(b);
                for (int c = 0; c < MEM_CHANNELS; c++) begin
                    em.lanes[c] = core_req.lanes[b*MEM_CHANNELS + c];
                end
                exp_mem_q.push_back(em);
            end
        end
    endtask

    task automatic observe_mem_req();
        mem_rsp_t              rsp;
        logic [TAG_WIDTH-1:0]  tag;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] word;
        int                    lane;
        if (!(mem_req_valid && mem_req_ready)) begin
            return;
        end
        if (exp_mem_q.size() == 0) begin
            other_errors++;
            $display("Error at %0t: memory request issued when none was due", $time);
            return;
        end
        check_mem_req(mem_req, exp_mem_q.pop_front(), "memory request");
        rsp      = '0;
        rsp.mask = mem_req.mask;
        rsp.tag  = mem_req.tag;
        tag      = slot_tag[mem_req.tag.slot];
        for (int c = 0; c < MEM_CHANNELS; c++) begin
            lane = int'(mem_req.tag.batch) * MEM_CHANNELS + c;
            addr = mem_req.lanes[c].addr;
            if (mem_req.mask[c] && mem_req.op == MEM_WRITE) begin
                word = read_word(addr);
                for (int by = 0; by < BYTEEN_WIDTH; by++) begin
                    if (mem_req.lanes[c].byteen[by]) begin
                        word[by*8 +: 8] = mem_req.lanes[c].data[by*8 +: 8];
                    end
                end
                mem_words[addr] = word;
            end else if (mem_req.mask[c]) begin
                rsp.data[c]         = read_word(addr);
                exp_data[tag][lane] = rsp.data[c];
            end
        end
        if (mem_req.op == MEM_READ) begin
            rsp_pend.push_back(rsp);
        end
    endtask

    // A read is complete once memory has returned all its lanes
    task automatic track_rsp_lanes(input mem_rsp_t rsp);
        logic [TAG_WIDTH-1:0] tag;
        tag = slot_tag[rsp.tag.slot];
        for (int c = 0; c < MEM_CHANNELS; c++) begin
            if (rsp.mask[c]) begin
                lanes_left[tag][int'(rsp.tag.batch) * MEM_CHANNELS + c] = 1'b0;
            end
        end
        if (lanes_left[tag] == '0) begin
            done_q.push_back(tag);
        end
    endtask

    task automatic observe_core_rsp();
        core_rsp_t            expected;
        logic [TAG_WIDTH-1:0] tag;
        if (core_rsp_valid && !core_rsp_ready && mem_rsp_ready) begin
            other_errors++;
            $display("Error at %0t: mem_rsp_ready high while the core response is stalled",
                     $time);
        end
        if (!(core_rsp_valid && core_rsp_ready)) begin
            return;
        end
        if (done_q.size() == 0) begin
            other_errors++;
            $display("Error at %0t: core response sent with no read completed", $time);
            return;
        end
        tag           = done_q.pop_front();
        expected      = '0;
        expected.mask = exp_mask[tag];
        expected.tag  = tag;
        for (int l = 0; l < CORE_REQS; l++) begin
            expected.data[l] = exp_data[tag][l];
        end
        check_core_rsp(core_rsp, expected, "core response");
        slot_busy[tag_slot[tag]] = 1'b0;
        open_reads--;
    endtask

    // Monitor samples mid-cycle, where every signal is settled
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                observe_core_req();
                observe_mem_req();
                observe_core_rsp();
            end
        end
    end

    task automatic stall_randomly();
        forever begin
            @(posedge clk);
            #2;
            if (!reset) begin
                mem_req_ready  = ($urandom % 4) != 0;
                core_rsp_ready = ($urandom % 3) != 0;
            end
        end
    endtask

    // Memory responses in random order with random gaps
    task automatic answer_mem_reqs();
        int       idx;
        int       tmo;
        mem_rsp_t rsp;
        forever begin
            @(posedge clk);
            #2;
            if (!reset && rsp_pend.size() != 0 && ($urandom % 3) == 0) begin
                idx           = int'($urandom % rsp_pend.size());
                rsp           = rsp_pend[idx];
                mem_rsp       = rsp;
                mem_rsp_valid = 1'b1;
                rsp_pend.delete(idx);
                tmo = 0;
                @(negedge clk);
                while (!mem_rsp_ready) begin
                    tmo++;
                    if (tmo == WAIT_LIMIT) timeout_fail("memory response never accepted");
                    @(negedge clk);
                end
                @(posedge clk);
                track_rsp_lanes(rsp);
                #2;
                mem_rsp_valid = 1'b0;
            end
        end
    endtask

    initial begin
        int tmo;
        void'($urandom(32'hf7fe));
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        mem_req_ready  = 1'b1;
        core_rsp_ready = 1'b1;
        mem_rsp        = '0;
        mem_rsp_valid  = 1'b0;
        fork
            stall_randomly();
            answer_mem_reqs();
        join_none
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < NUM_STIM; i++) begin
            @(posedge clk);
            #2;
            core_req       = make_req(STIM[i]);
            core_req_valid = 1'b1;
            tmo = 0;
            @(negedge clk);
            while (!core_req_ready) begin
                tmo++;
                if (tmo == WAIT_LIMIT) timeout_fail("core request never accepted");
                @(negedge clk);
            end
        end
        @(posedge clk);
        #2;
        core_req_valid = 1'b0;

        tmo = 0;
        while (open_reads != 0 || exp_mem_q.size() != 0) begin
            tmo++;
            if (tmo == WAIT_LIMIT) timeout_fail("reads or memory requests still outstanding");
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if (stall_cycles == 0) begin
            other_errors++;
            $display("Error: no read was ever held off while all slots were busy");
        end
        $display("Errors: %0d check failures, %0d other errors", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/mem_sched_pkg.sv
rtl/req_queue.sv
rtl/slot_table.sv
rtl/batch_issuer.sv
rtl/rsp_gatherer.sv
rtl/mem_scheduler.sv
dv/mem_sched_assertions.sv
dv/tb_mem_scheduler.sv

// File: Makefile
TOP := tb_mem_scheduler
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f rtl/*.sv dv/*.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then exit 1; fi

lint:
	verilator --lint-only -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)
